//--- logic/rv_csr_pkg.sv
// CSR address map, field widths, ID constants, and the CSR command and response structs.
`default_nettype none

package rv_csr_pkg;

    // Field widths of the CSR port.
    localparam int CSR_ADDR_W = 12;
    localparam int CSR_DATA_W = 32;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;

    // Machine information registers.
    localparam csr_addr_t CSR_MVENDORID = 12'hf11;
    localparam csr_addr_t CSR_MARCHID   = 12'hf12;
    localparam csr_addr_t CSR_MIMPID    = 12'hf13;
    localparam csr_addr_t CSR_MHARTID   = 12'hf14;

    // Machine trap setup.
    localparam csr_addr_t CSR_MSTATUS   = 12'h300;
    localparam csr_addr_t CSR_MISA      = 12'h301;
    localparam csr_addr_t CSR_MEDELEG   = 12'h302;
    localparam csr_addr_t CSR_MIDELEG   = 12'h303;
    localparam csr_addr_t CSR_MIE       = 12'h304;
    localparam csr_addr_t CSR_MTVEC     = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH  = 12'h310;

    // Machine trap handling.
    localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
    localparam csr_addr_t CSR_MEPC      = 12'h341;
    localparam csr_addr_t CSR_MCAUSE    = 12'h342;
    localparam csr_addr_t CSR_MTVAL     = 12'h343;
    localparam csr_addr_t CSR_MIP       = 12'h344;

    // MXL encoding for RV32, and extension letters in misa.
    localparam logic [1:0] MISA_MXL_32 = 2'b01;
    localparam int MISA_BIT_C = 2;
    localparam int MISA_BIT_I = 8;
    localparam int MISA_BIT_M = 12;

    // Architecture and implementation IDs.
    localparam csr_data_t  MARCH_ID           = 32'd37;
    localparam logic [7:0] IMPL_VERSION_MAJOR = 8'd1;
    localparam logic [3:0] IMPL_VERSION_MINOR = 4'd4;

    // mstatus bit positions.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // One access from the port, valid for one cycle.
    typedef struct packed {
        logic      valid;
        logic      we;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_cmd_t;

    // Read decode result for the addressed CSR.
    typedef struct packed {
        logic      exists;
        logic      rdonly;
        csr_data_t rdata;
    } csr_resp_t;

endpackage

`default_nettype wire

//--- logic/trap_pkg.sv
// Trap types, interrupt constants, retirement report and exception decision structs.
`default_nettype none

package trap_pkg;

    // Halfword-aligned PC.
    typedef logic [31:1] pc_t;
    // Trap vector base, word aligned.
    typedef logic [31:2] tvec_t;
    // Trap or interrupt number.
    typedef logic [4:0]  cause_t;
    // One bit per interrupt number.
    typedef logic [31:0] irq_vec_t;
    // External lines map onto causes 16 to 31.
    typedef logic [31:16] ext_irq_t;

    // Machine timer interrupt number.
    localparam cause_t IRQ_TIMER = 5'd7;

    // Cycles MIE must already be set before an interrupt can be taken.
    localparam int IRQ_EN_DEPTH = 2;

    // Report from the retiring instruction.
    typedef struct packed {
        logic   valid;
        logic   trap;
        cause_t cause;
        pc_t    pc;
    } retire_t;

    // Exception decision for this cycle.
    typedef struct packed {
        logic   taken;
        logic   is_irq;
        cause_t cause;
        pc_t    epc;
        tvec_t  tvec;
    } exc_t;

endpackage

`default_nettype wire

//--- logic/csr_access.sv
// Four-phase req/ack slave turning one external access into a single-cycle CSR command.
`default_nettype none

module csr_access (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  req,
    input  wire logic                  we,
    input  wire rv_csr_pkg::csr_addr_t addr,
    input  wire rv_csr_pkg::csr_data_t wdata,
    output logic                       ack,
    output rv_csr_pkg::csr_resp_t      resp,
    output rv_csr_pkg::csr_cmd_t       cmd,
    input  wire rv_csr_pkg::csr_resp_t cmd_resp
);
    typedef enum logic {
        IDLE,
        ACK
    } state_t;

    state_t state;
    logic   start;

    // New access is accepted only from idle.
    assign start = (state == IDLE) && req;

    // Master holds addr and wdata stable while req is high.
    assign cmd.valid = start;
    assign cmd.we    = we;
    assign cmd.addr  = addr;
    assign cmd.wdata = wdata;

    assign ack = (state == ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    // Hold ack until the master drops req.
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Capture on the accepting edge, before the write lands.
    always_ff @(posedge clk) begin
        if (start) begin
            resp <= cmd_resp;
        end
    end

endmodule

`default_nettype wire

//--- logic/csr_file.sv
// Machine CSR storage, read and write decode, trap entry and MRET updates.
`default_nettype none

module csr_file #(
    parameter rv_csr_pkg::csr_data_t hart_id = 32'h0000_0000,
    parameter bit                    has_m   = 1'b1,
    parameter bit                    has_c   = 1'b1
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire rv_csr_pkg::csr_cmd_t  cmd,
    output rv_csr_pkg::csr_resp_t      cmd_resp,
    input  wire trap_pkg::exc_t        exc,
    input  wire logic                  mret,
    input  wire trap_pkg::irq_vec_t    irq_ip,
    output trap_pkg::irq_vec_t         mie,
    output logic                       mstatus_mie,
    output trap_pkg::tvec_t            mtvec,
    output trap_pkg::pc_t              ret_epc
);
    // Fixed misa, MXL plus base and enabled extensions.
    localparam rv_csr_pkg::csr_data_t misa_val =
        {rv_csr_pkg::MISA_MXL_32, 30'd0}
        | (32'd1 << rv_csr_pkg::MISA_BIT_I)
        | (32'(has_m) << rv_csr_pkg::MISA_BIT_M)
        | (32'(has_c) << rv_csr_pkg::MISA_BIT_C);

    // Version in bits 15 to 4, patch level zero.
    localparam rv_csr_pkg::csr_data_t mimpid_val =
        {16'd0, rv_csr_pkg::IMPL_VERSION_MAJOR, rv_csr_pkg::IMPL_VERSION_MINOR, 4'd0};

    logic                  mstatus_mpie;
    rv_csr_pkg::csr_data_t mscratch;
    trap_pkg::pc_t         mepc;
    logic                  mcause_int;
    trap_pkg::cause_t      mcause_no;
    rv_csr_pkg::csr_data_t mstatus_val;
    rv_csr_pkg::csr_data_t mcause_val;
    logic                  wr;

    assign ret_epc = mepc;
    assign wr      = cmd.valid && cmd.we;

    always_comb begin
        mstatus_val = '0;
        mstatus_val[rv_csr_pkg::MSTATUS_MIE_BIT]  = mstatus_mie;
        mstatus_val[rv_csr_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie;
    end

    // Interrupt flag in the top bit.
    assign mcause_val = {mcause_int, 26'd0, mcause_no};

    // Read decode.
    always_comb begin
        cmd_resp.exists = 1'b1;
        cmd_resp.rdonly = 1'b0;
        cmd_resp.rdata  = '0;
        case (cmd.addr)
            rv_csr_pkg::CSR_MSTATUS:   cmd_resp.rdata = mstatus_val;
            rv_csr_pkg::CSR_MIE:       cmd_resp.rdata = mie;
            rv_csr_pkg::CSR_MTVEC:     cmd_resp.rdata = {mtvec, 2'b00};
            rv_csr_pkg::CSR_MIP:       cmd_resp.rdata = irq_ip & mie;
            rv_csr_pkg::CSR_MSCRATCH:  cmd_resp.rdata = mscratch;
            rv_csr_pkg::CSR_MEPC:      cmd_resp.rdata = {mepc, 1'b0};
            rv_csr_pkg::CSR_MCAUSE:    cmd_resp.rdata = mcause_val;
            // No delegation, no upper status and no trap value.
            rv_csr_pkg::CSR_MEDELEG,
            rv_csr_pkg::CSR_MIDELEG,
            rv_csr_pkg::CSR_MSTATUSH,
            rv_csr_pkg::CSR_MTVAL:     cmd_resp.rdata = '0;
            // Constant registers.
            rv_csr_pkg::CSR_MISA: begin
                cmd_resp.rdonly = 1'b1;
                cmd_resp.rdata  = misa_val;
            end
            rv_csr_pkg::CSR_MVENDORID: cmd_resp.rdonly = 1'b1;
            rv_csr_pkg::CSR_MARCHID: begin
                cmd_resp.rdonly = 1'b1;
                cmd_resp.rdata  = rv_csr_pkg::MARCH_ID;
            end
            rv_csr_pkg::CSR_MIMPID: begin
                cmd_resp.rdonly = 1'b1;
                cmd_resp.rdata  = mimpid_val;
            end
            rv_csr_pkg::CSR_MHARTID: begin
                cmd_resp.rdonly = 1'b1;
                cmd_resp.rdata  = hart_id;
            end
            default:                   cmd_resp.exists = 1'b0;
        endcase
    end

    // Trap entry, then port write, then return.
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie          <= '0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause_int   <= 1'b0;
            mcause_no    <= '0;
        end else if (exc.taken) begin
            // Stack MIE and record the cause.
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= exc.epc;
            mcause_int   <= exc.is_irq;
            mcause_no    <= exc.cause;
        end else if (wr) begin
            case (cmd.addr)
                rv_csr_pkg::CSR_MSTATUS: begin
                    mstatus_mie  <= cmd.wdata[rv_csr_pkg::MSTATUS_MIE_BIT];
                    mstatus_mpie <= cmd.wdata[rv_csr_pkg::MSTATUS_MPIE_BIT];
                end
                rv_csr_pkg::CSR_MIE:      mie      <= cmd.wdata;
                rv_csr_pkg::CSR_MTVEC:    mtvec    <= cmd.wdata[31:2];
                rv_csr_pkg::CSR_MSCRATCH: mscratch <= cmd.wdata;
                rv_csr_pkg::CSR_MEPC:     mepc     <= cmd.wdata[31:1];
                rv_csr_pkg::CSR_MCAUSE: begin
                    mcause_int <= cmd.wdata[31];
                    mcause_no  <= cmd.wdata[4:0];
                end
                // Everything else ignores writes.
                default: begin
                end
            endcase
        end else if (mret) begin
            mstatus_mie <= mstatus_mpie;
        end
    end

endmodule

`default_nettype wire

//--- logic/irq_arbiter.sv
// Interrupt latch, mask, lowest-number priority encoder and enable settle pipeline.
`default_nettype none

module irq_arbiter (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire trap_pkg::ext_irq_t ext_irq,
    input  wire logic               timer_irq,
    input  wire trap_pkg::irq_vec_t mie,
    input  wire logic               mstatus_mie,
    output trap_pkg::irq_vec_t      irq_ip,
    output logic                    irq_pending,
    output trap_pkg::cause_t        irq_cause,
    output logic                    irq_enable
);
    trap_pkg::irq_vec_t              irq_masked;
    logic [trap_pkg::IRQ_EN_DEPTH-1:0] en_pipe;

    // Register lines into cause positions, one cycle latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_ip <= '0;
        end else begin
            irq_ip                     <= '0;
            irq_ip[31:16]              <= ext_irq;
            irq_ip[trap_pkg::IRQ_TIMER] <= timer_irq;
        end
    end

    assign irq_masked  = irq_ip & mie;
    assign irq_pending = |irq_masked;

    // Lowest number wins.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_masked[i]) begin
                irq_cause = trap_pkg::cause_t'(i);
            end
        end
    end

    // MIE history.
    always_ff @(posedge clk) begin
        if (rst) begin
            en_pipe <= '0;
        end else begin
            en_pipe <= {en_pipe[trap_pkg::IRQ_EN_DEPTH-2:0], mstatus_mie};
        end
    end

    // Taken only once MIE has been stable for the full depth.
    assign irq_enable = (&en_pipe) && mstatus_mie;

endmodule

`default_nettype wire

//--- logic/trap_dispatch.sv
// Exception decision from the pending interrupt and the retirement report.
`default_nettype none

module trap_dispatch (
    input  wire trap_pkg::retire_t retire,
    input  wire logic              irq_pending,
    input  wire trap_pkg::cause_t  irq_cause,
    input  wire logic              irq_enable,
    input  wire trap_pkg::tvec_t   mtvec,
    output trap_pkg::exc_t         exc
);
    always_comb begin
        exc.taken  = 1'b0;
        exc.is_irq = 1'b0;
        exc.cause  = '0;
        // Both kinds return to the retiring instruction.
        exc.epc    = retire.pc;
        exc.tvec   = mtvec;
        if (irq_pending && irq_enable && retire.valid) begin
            // Interrupts only at an instruction boundary.
            exc.taken  = 1'b1;
            exc.is_irq = 1'b1;
            exc.cause  = irq_cause;
        end else if (retire.trap) begin
            // Synchronous trap.
            exc.taken  = 1'b1;
            exc.cause  = retire.cause;
        end
    end

endmodule

`default_nettype wire

//--- logic/machine_trap_unit.sv
// Machine-mode trap unit top level with CSR port, interrupt arbiter and trap dispatch.
`default_nettype none

module machine_trap_unit #(
    parameter rv_csr_pkg::csr_data_t hart_id = 32'h0000_0000,
    parameter bit                    has_m   = 1'b1,
    parameter bit                    has_c   = 1'b1
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  req,
    input  wire logic                  we,
    input  wire rv_csr_pkg::csr_addr_t addr,
    input  wire rv_csr_pkg::csr_data_t wdata,
    output logic                       ack,
    output rv_csr_pkg::csr_data_t      rdata,
    output logic                       exists,
    output logic                       rdonly,
    input  wire trap_pkg::retire_t     retire,
    input  wire logic                  mret,
    input  wire trap_pkg::ext_irq_t    ext_irq,
    input  wire logic                  timer_irq,
    output trap_pkg::exc_t             exc,
    output trap_pkg::pc_t              ret_epc
);
    rv_csr_pkg::csr_cmd_t  cmd;
    rv_csr_pkg::csr_resp_t cmd_resp;
    rv_csr_pkg::csr_resp_t resp;
    trap_pkg::irq_vec_t    irq_ip;
    trap_pkg::irq_vec_t    mie;
    trap_pkg::tvec_t       mtvec;
    trap_pkg::cause_t      irq_cause;
    logic                  mstatus_mie;
    logic                  irq_pending;
    logic                  irq_enable;

    // Captured response to the master.
    assign rdata  = resp.rdata;
    assign exists = resp.exists;
    assign rdonly = resp.rdonly;

    csr_access i_csr_access (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .we       (we),
        .addr     (addr),
        .wdata    (wdata),
        .ack      (ack),
        .resp     (resp),
        .cmd      (cmd),
        .cmd_resp (cmd_resp)
    );

    csr_file #(
        .hart_id (hart_id),
        .has_m   (has_m),
        .has_c   (has_c)
    ) i_csr_file (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmd_resp    (cmd_resp),
        .exc         (exc),
        .mret        (mret),
        .irq_ip      (irq_ip),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .mtvec       (mtvec),
        .ret_epc     (ret_epc)
    );

    irq_arbiter i_irq_arbiter (
        .clk         (clk),
        .rst         (rst),
        .ext_irq     (ext_irq),
        .timer_irq   (timer_irq),
        .mie         (mie),
        .mstatus_mie (mstatus_mie),
        .irq_ip      (irq_ip),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_enable  (irq_enable)
    );

    trap_dispatch i_trap_dispatch (
        .retire      (retire),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_enable  (irq_enable),
        .mtvec       (mtvec),
        .exc         (exc)
    );

endmodule

`default_nettype wire

//--- verif/trap_checker.sv
// Port monitor comparing CSR responses, exception decisions and ret_epc with expected values.
`default_nettype none

module trap_checker (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  ack,
    input  wire rv_csr_pkg::csr_data_t rdata,
    input  wire logic                  exists,
    input  wire logic                  rdonly,
    input  wire trap_pkg::retire_t     retire,
    input  wire trap_pkg::exc_t        exc,
    input  wire trap_pkg::pc_t         ret_epc,
    input  wire rv_csr_pkg::csr_resp_t exp_resp,
    input  wire trap_pkg::exc_t        exp_exc,
    input  wire trap_pkg::pc_t         exp_epc,
    output int                         errors,
    output int                         checks
);
    logic ack_q;
    logic resp_bad;
    logic exc_bad;

    always @(posedge clk) begin
        if (rst) begin
            ack_q  <= 1'b0;
            errors = 0;
            checks = 0;
        end else begin
            ack_q <= ack;
            // Response is registered one edge before ack shows high.
            if (ack && !ack_q) begin
                checks   = checks + 1;
                resp_bad = (exists !== exp_resp.exists);
                if (exp_resp.exists) begin
                    resp_bad = resp_bad || (rdonly !== exp_resp.rdonly)
                        || (rdata !== exp_resp.rdata);
                end
                if (resp_bad) begin
                    errors = errors + 1;
                    $display("ERROR at %0t: exists/rdonly/rdata %b %b %h, expected %b %b %h",
                        $time, exists, rdonly, rdata,
                        exp_resp.exists, exp_resp.rdonly, exp_resp.rdata);
                end
            end
            // Decision only matters at an instruction boundary.
            if (retire.valid) begin
                checks  = checks + 1;
                exc_bad = (exc.taken !== exp_exc.taken) || (exc.epc !== exp_exc.epc)
                    || (exc.tvec !== exp_exc.tvec);
                if (exp_exc.taken) begin
                    exc_bad = exc_bad || (exc.is_irq !== exp_exc.is_irq)
                        || (exc.cause !== exp_exc.cause);
                end
                if (exc_bad) begin
                    errors = errors + 1;
                    $display("ERROR at %0t: exc %h, expected %h", $time, exc, exp_exc);
                end
            end
            // Return address tracks mepc at all times.
            if (ret_epc !== exp_epc) begin
                errors = errors + 1;
                $display("ERROR at %0t: ret_epc %h, expected %h", $time, ret_epc, exp_epc);
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_machine_trap_unit.sv
// Testbench top with clock, reset, CSR model, stimulus sequence, DUT, checker and watchdog.
`default_nettype none

module tb_machine_trap_unit;

    localparam rv_csr_pkg::csr_data_t HART_ID = 32'h0000_0005;
    localparam bit HAS_M = 1'b1;
    localparam bit HAS_C = 1'b0;
    // Operations in the main sequence, rounded up.
    localparam int NUM_OPS = 64;

    logic                  clk;
    logic                  rst;
    logic                  req;
    logic                  we;
    rv_csr_pkg::csr_addr_t addr;
    rv_csr_pkg::csr_data_t wdata;
    logic                  ack;
    rv_csr_pkg::csr_data_t rdata;
    logic                  exists;
    logic                  rdonly;
    trap_pkg::retire_t     retire;
    logic                  mret;
    trap_pkg::ext_irq_t    ext_irq;
    logic                  timer_irq;
    trap_pkg::exc_t        exc;
    trap_pkg::pc_t         ret_epc;

    rv_csr_pkg::csr_resp_t exp_resp;
    trap_pkg::exc_t        exp_exc;
    int                    errors;
    int                    checks;
    int                    port_errors;

    // CSR state model.
    logic                  m_mst_mie;
    logic                  m_mpie;
    trap_pkg::irq_vec_t    m_mie;
    trap_pkg::tvec_t       m_mtvec;
    rv_csr_pkg::csr_data_t m_mscratch;
    trap_pkg::pc_t         m_mepc;
    rv_csr_pkg::csr_data_t m_mcause;
    trap_pkg::irq_vec_t    m_lines;

    machine_trap_unit #(
        .hart_id (HART_ID),
        .has_m   (HAS_M),
        .has_c   (HAS_C)
    ) i_machine_trap_unit (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .exists    (exists),
        .rdonly    (rdonly),
        .retire    (retire),
        .mret      (mret),
        .ext_irq   (ext_irq),
        .timer_irq (timer_irq),
        .exc       (exc),
        .ret_epc   (ret_epc)
    );

    trap_checker i_trap_checker (
        .clk      (clk),
        .rst      (rst),
        .ack      (ack),
        .rdata    (rdata),
        .exists   (exists),
        .rdonly   (rdonly),
        .retire   (retire),
        .exc      (exc),
        .ret_epc  (ret_epc),
        .exp_resp (exp_resp),
        .exp_exc  (exp_exc),
        .exp_epc  (m_mepc),
        .errors   (errors),
        .checks   (checks)
    );

    always #20 clk = ~clk;

    // Expected read response from the model, old value for a write.
    function automatic rv_csr_pkg::csr_resp_t model_read(input rv_csr_pkg::csr_addr_t a);
        rv_csr_pkg::csr_resp_t r;
        r.exists = 1'b1;
        r.rdonly = 1'b0;
        r.rdata  = '0;
        case (a)
            rv_csr_pkg::CSR_MSTATUS: begin
                r.rdata[rv_csr_pkg::MSTATUS_MIE_BIT]  = m_mst_mie;
                r.rdata[rv_csr_pkg::MSTATUS_MPIE_BIT] = m_mpie;
            end
            rv_csr_pkg::CSR_MIE:      r.rdata = m_mie;
            rv_csr_pkg::CSR_MTVEC:    r.rdata = {m_mtvec, 2'b00};
            rv_csr_pkg::CSR_MSCRATCH: r.rdata = m_mscratch;
            rv_csr_pkg::CSR_MEPC:     r.rdata = {m_mepc, 1'b0};
            rv_csr_pkg::CSR_MCAUSE:   r.rdata = m_mcause;
            rv_csr_pkg::CSR_MISA: begin
                // Letters I, M and C sit at bits 8, 12 and 2.
                r.rdonly     = 1'b1;
                r.rdata      = {rv_csr_pkg::MISA_MXL_32, 30'd0};
                r.rdata[8]   = 1'b1;
                r.rdata[12]  = HAS_M;
                r.rdata[2]   = HAS_C;
            end
            rv_csr_pkg::CSR_MARCHID: begin
                r.rdonly = 1'b1;
                r.rdata  = rv_csr_pkg::MARCH_ID;
            end
            rv_csr_pkg::CSR_MHARTID: begin
                r.rdonly = 1'b1;
                r.rdata  = HART_ID;
            end
            default: r.exists = 1'b0;
        endcase
        return r;
    endfunction

    function automatic trap_pkg::cause_t lowest_cause(input trap_pkg::irq_vec_t v);
        trap_pkg::cause_t c;
        logic             found;
        c     = '0;
        found = 1'b0;
        for (int i = 0; i < 32; i++) begin
            if (v[i] && !found) begin
                c     = trap_pkg::cause_t'(i);
                found = 1'b1;
            end
        end
        return c;
    endfunction

    // Expected decision, assuming lines and MIE have settled.
    function automatic trap_pkg::exc_t model_exc(input trap_pkg::retire_t r);
        trap_pkg::exc_t e;
        e        = '0;
        e.epc    = r.pc;
        e.tvec   = m_mtvec;
        if (r.valid && m_mst_mie && ((m_lines & m_mie) != '0)) begin
            e.taken  = 1'b1;
            e.is_irq = 1'b1;
            e.cause  = lowest_cause(m_lines & m_mie);
        end else if (r.trap) begin
            e.taken = 1'b1;
            e.cause = r.cause;
        end
        return e;
    endfunction

    function automatic trap_pkg::pc_t rand_pc();
        return trap_pkg::pc_t'($urandom);
    endfunction

    task automatic model_write(input rv_csr_pkg::csr_addr_t a, input rv_csr_pkg::csr_data_t d);
        case (a)
            rv_csr_pkg::CSR_MSTATUS: begin
                m_mst_mie = d[rv_csr_pkg::MSTATUS_MIE_BIT];
                m_mpie    = d[rv_csr_pkg::MSTATUS_MPIE_BIT];
            end
            rv_csr_pkg::CSR_MIE:      m_mie      = d;
            rv_csr_pkg::CSR_MTVEC:    m_mtvec    = d[31:2];
            rv_csr_pkg::CSR_MSCRATCH: m_mscratch = d;
            rv_csr_pkg::CSR_MEPC:     m_mepc     = d[31:1];
            rv_csr_pkg::CSR_MCAUSE:   m_mcause   = {d[31], 26'd0, d[4:0]};
            default: begin
            end
        endcase
    endtask

    // Full four-phase access, entered and left on a falling edge.
    task automatic csr_transfer(input logic wr, input rv_csr_pkg::csr_addr_t a,
                                input rv_csr_pkg::csr_data_t d);
        int waited;
        req      = 1'b1;
        we       = wr;
        addr     = a;
        wdata    = d;
        exp_resp = model_read(a);
        waited   = 0;
        while (!ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            $display("Handshake failure: no ack within 20 cycles for CSR %h", a);
            port_errors++;
        end else if (wr) begin
            model_write(a, d);
        end
        req    = 1'b0;
        waited = 0;
        while (ack && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            $display("Handshake failure: ack stayed high after req fell for CSR %h", a);
            port_errors++;
        end
    endtask

    task automatic write_read(input rv_csr_pkg::csr_addr_t a);
        csr_transfer(1'b1, a, $urandom);
        csr_transfer(1'b0, a, '0);
    endtask

    // Waits for lines and the enable pipeline to settle, then retires one instruction.
    task automatic retire_insn(input logic trap, input trap_pkg::cause_t cause,
                               input trap_pkg::pc_t pc);
        trap_pkg::retire_t r;
        trap_pkg::exc_t    e;
        repeat (4) @(negedge clk);
        r.valid = 1'b1;
        r.trap  = trap;
        r.cause = cause;
        r.pc    = pc;
        e       = model_exc(r);
        retire  = r;
        exp_exc = e;
        @(negedge clk);
        retire = '0;
        if (e.taken) begin
            m_mpie    = m_mst_mie;
            m_mst_mie = 1'b0;
            m_mepc    = e.epc;
            m_mcause  = {e.is_irq, 26'd0, e.cause};
        end
    endtask

    task automatic mret_pulse();
        mret = 1'b1;
        @(negedge clk);
        mret      = 1'b0;
        m_mst_mie = m_mpie;
    endtask

    initial begin
        rv_csr_pkg::csr_data_t mask;
        trap_pkg::ext_irq_t    ext_val;
        void'($urandom(58));
        clk         = 1'b0;
        rst         = 1'b1;
        req         = 1'b0;
        we          = 1'b0;
        addr        = '0;
        wdata       = '0;
        retire      = '0;
        mret        = 1'b0;
        ext_irq     = '0;
        timer_irq   = 1'b0;
        exp_resp    = '0;
        exp_exc     = '0;
        port_errors = 0;
        m_mst_mie   = 1'b0;
        m_mpie      = 1'b0;
        m_mie       = '0;
        m_mtvec     = '0;
        m_mscratch  = '0;
        m_mepc      = '0;
        m_mcause    = '0;
        m_lines     = '0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // Reset state.
        if (ack !== 1'b0) begin
            $display("ERROR at %0t: ack is %b after reset", $time, ack);
            port_errors++;
        end
        retire_insn(1'b0, '0, rand_pc());
        csr_transfer(1'b0, rv_csr_pkg::CSR_MSTATUS, '0);
        csr_transfer(1'b0, rv_csr_pkg::CSR_MIE, '0);
        csr_transfer(1'b0, rv_csr_pkg::CSR_MTVEC, '0);
        csr_transfer(1'b0, rv_csr_pkg::CSR_MEPC, '0);
        csr_transfer(1'b0, rv_csr_pkg::CSR_MCAUSE, '0);

        // Write and read back, low bits of mtvec and mepc read as zero.
        for (int k = 0; k < 3; k++) begin
            write_read(rv_csr_pkg::CSR_MSCRATCH);
            write_read(rv_csr_pkg::CSR_MTVEC);
            write_read(rv_csr_pkg::CSR_MEPC);
        end

        // Constant registers and an unmapped address.
        write_read(rv_csr_pkg::CSR_MHARTID);
        write_read(rv_csr_pkg::CSR_MARCHID);
        write_read(rv_csr_pkg::CSR_MISA);
        write_read(12'h7c0);

        // Synchronous trap with MIE set, then MRET.
        csr_transfer(1'b1, rv_csr_pkg::CSR_MSTATUS, 32'h0000_0008);
        retire_insn(1'b1, trap_pkg::cause_t'($urandom_range(0, 31)), rand_pc());
        csr_transfer(1'b0, rv_csr_pkg::CSR_MEPC, '0);
        csr_transfer(1'b0, rv_csr_pkg::CSR_MCAUSE, '0);
        csr_transfer(1'b0, rv_csr_pkg::CSR_MSTATUS, '0);
        mret_pulse();
        csr_transfer(1'b0, rv_csr_pkg::CSR_MSTATUS, '0);

        // Interrupts: timer enabled only in the first round.
        for (int k = 0; k < 3; k++) begin
            ext_val   = trap_pkg::ext_irq_t'($urandom);
            ext_irq   = ext_val;
            timer_irq = 1'b1;
            m_lines   = {ext_val, 8'd0, 1'b1, 7'd0};
            mask      = ($urandom & 32'hffff_0000) | ((k == 0) ? 32'h80 : 32'h0);
            csr_transfer(1'b1, rv_csr_pkg::CSR_MIE, mask);
            csr_transfer(1'b1, rv_csr_pkg::CSR_MSTATUS, 32'h0000_0008);
            retire_insn(1'b0, '0, rand_pc());
            csr_transfer(1'b0, rv_csr_pkg::CSR_MCAUSE, '0);
            // MIE now clear, lines still high.
            retire_insn(1'b0, '0, rand_pc());
            mret_pulse();
            csr_transfer(1'b0, rv_csr_pkg::CSR_MSTATUS, '0);
        end
        ext_irq   = '0;
        timer_irq = 1'b0;
        m_lines   = '0;
        repeat (3) @(negedge clk);

        $display("Checks: %0d, value errors: %0d, handshake errors: %0d",
            checks, errors, port_errors);
        if (errors == 0 && port_errors == 0 && checks > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog, 40 cycles per planned operation.
    initial begin
        #(NUM_OPS * 40 * 40);
        $display("Watchdog: the test sequence did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/rv_csr_pkg.sv
logic/trap_pkg.sv
logic/csr_access.sv
logic/csr_file.sv
logic/irq_arbiter.sv
logic/trap_dispatch.sv
logic/machine_trap_unit.sv
verif/trap_checker.sv
verif/tb_machine_trap_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then look for the pass line in the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -f compile.f --top-module tb_machine_trap_unit -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation did not complete"

cat sim.log 2>/dev/null

grep -q "All tests passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED"; exit 1; }
